// File: design/hdr_consts.svh
`ifndef HDR_CONSTS_SVH
`define HDR_CONSTS_SVH

// character index and left count width
`define HDR_CHAR_W 8

// backtrack run counter width
`define HDR_RUN_W 8

// a run reaching this many zeros goes out as its own event
`define HDR_RUN_MAX 255

// event FIFO entries
`define HDR_QUEUE_DEPTH 8

`endif

// File: design/hdr_pkg.sv
`default_nettype none

`include "hdr_consts.svh"

package hdr_pkg;

    // event kinds queued between input side and serializer
    typedef enum logic [1:0] {
        // leaf record, 1 + char index and maybe 1 + left count
        EV_CHAR = 2'd0,
        // saturated backtrack run, zeros only
        EV_RUN  = 2'd1,
        // end of walk, pending zeros then flush
        EV_END  = 2'd2
    } hdr_kind_t;

    // one queued event, 27 bits
    typedef struct packed {
        hdr_kind_t               kind;
        // zeros sent ahead of the event's own fields
        logic [`HDR_RUN_W-1:0]   lead_zeros;
        logic [`HDR_CHAR_W-1:0]  char_index;
        // leaf is a left child
        logic                    left;
        logic [`HDR_CHAR_W-1:0]  num_lefts;
    } hdr_event_t;

endpackage

`default_nettype wire

// File: design/hdr_event_if.sv
`timescale 1ns/1ps
`default_nettype none

// event handoff from the input FIFO to the bit serializer
interface hdr_event_if import hdr_pkg::*; ();

    // head entry present
    logic       not_empty;
    // head entry, valid while not_empty
    hdr_event_t event_word;
    // single-cycle strobe, head advances on this edge
    logic       pop;

    // FIFO side
    modport queue (
        output not_empty,
        output event_word,
        input  pop
    );

    // serializer side, pop only while not_empty
    modport serializer (
        input  not_empty,
        input  event_word,
        output pop
    );

endinterface

`default_nettype wire

// File: design/hdr_event_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdr_consts.svh"

module hdr_event_queue import hdr_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   char_found,
    input  logic [`HDR_CHAR_W-1:0] char_index,
    input  logic                   char_left,
    input  logic [`HDR_CHAR_W-1:0] num_lefts,
    input  logic                   backtrack,
    input  logic                   tree_done,
    hdr_event_if.queue             evq,
    output logic                   overflow
);

    localparam int DEPTH = `HDR_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(DEPTH);
    // counter value one short of a saturated run
    localparam logic [`HDR_RUN_W-1:0] RUN_LAST = `HDR_RUN_MAX - 1;
    localparam logic [`HDR_RUN_W-1:0] RUN_FULL = `HDR_RUN_MAX;

    logic [`HDR_RUN_W-1:0] run_cnt;
    logic [`HDR_RUN_W-1:0] run_next;
    logic                  wr_req;
    hdr_event_t            wr_event;

    hdr_event_t            mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic                  full;
    logic                  push;
    logic                  do_pop;

    // event build, one write per cycle at most
    always_comb begin
        wr_req   = 1'b0;
        run_next = run_cnt;
        // leaf fields by default, pending run rides along
        wr_event = '{kind: EV_CHAR, lead_zeros: run_cnt, char_index: char_index,
                     left: char_left, num_lefts: num_lefts};
        if (char_found) begin
            // leaf wins, same-cycle backtrack dropped
            wr_req   = 1'b1;
            run_next = '0;
        end else if (tree_done) begin
            wr_req        = 1'b1;
            wr_event.kind = EV_END;
            run_next      = '0;
        end else if (backtrack) begin
            if (run_cnt == RUN_LAST) begin
                // run saturates, flush as zeros-only event
                wr_req              = 1'b1;
                wr_event.kind       = EV_RUN;
                wr_event.lead_zeros = RUN_FULL;
                run_next            = '0;
            end else begin
                run_next = run_cnt + 1'b1;
            end
        end
    end

    assign full   = (count == COUNT_FULL);
    // write into a full FIFO is lost
    assign push   = wr_req && !full;
    assign do_pop = evq.pop && evq.not_empty;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            run_cnt  <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            run_cnt <= run_next;
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (wr_req && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_event;
        end
    end

    assign evq.not_empty  = (count != '0);
    assign evq.event_word = mem[rd_ptr];

endmodule

`default_nettype wire

// File: design/hdr_bit_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdr_consts.svh"

module hdr_bit_serializer import hdr_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    hdr_event_if.serializer evq,
    output logic           bit_valid,
    output logic           bit_value,
    output logic           end_strobe
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ZEROS,
        S_CHAR,
        S_LEFTS,
        S_END
    } ser_state_t;

    // bit index of the last field bit, 9 bits counted 8 down to 0
    localparam logic [3:0] FIELD_BITS = `HDR_CHAR_W;

    ser_state_t              state;
    hdr_event_t              ev_q;
    logic [`HDR_RUN_W-1:0]   zcnt;
    logic [3:0]              bcnt;
    // leading 1 plus 8-bit field, MSB out first
    logic [`HDR_CHAR_W:0]    shreg;

    // state once the zero run is done
    function automatic ser_state_t field_state(input hdr_event_t ev);
        ser_state_t st;
        case (ev.kind)
            EV_CHAR: st = S_CHAR;
            EV_END:  st = S_END;
            // saturated run has no fields
            default: st = S_IDLE;
        endcase
        return st;
    endfunction

    // pop straight from idle, head is latched on the same edge
    assign evq.pop = (state == S_IDLE) && evq.not_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            zcnt  <= '0;
            bcnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (evq.not_empty) begin
                        bcnt <= FIELD_BITS;
                        if (evq.event_word.lead_zeros != '0) begin
                            state <= S_ZEROS;
                            zcnt  <= evq.event_word.lead_zeros;
                        end else begin
                            state <= field_state(evq.event_word);
                        end
                    end
                end
                S_ZEROS: begin
                    // one zero per backtrack
                    zcnt <= zcnt - 1'b1;
                    if (zcnt == 1) begin
                        state <= field_state(ev_q);
                    end
                end
                S_CHAR: begin
                    if (bcnt == '0) begin
                        // left count only for left leaves with lefts pending
                        if (ev_q.left && ev_q.num_lefts != '0) begin
                            state <= S_LEFTS;
                            bcnt  <= FIELD_BITS;
                        end else begin
                            state <= S_IDLE;
                        end
                    end else begin
                        bcnt <= bcnt - 1'b1;
                    end
                end
                S_LEFTS: begin
                    if (bcnt == '0) begin
                        state <= S_IDLE;
                    end else begin
                        bcnt <= bcnt - 1'b1;
                    end
                end
                // single flush cycle
                S_END:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // event payload and field shifter
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (evq.not_empty) begin
                    ev_q  <= evq.event_word;
                    shreg <= {1'b1, evq.event_word.char_index};
                end
            end
            S_CHAR: begin
                // reload with the left-count field after the 9th bit
                if (bcnt == '0) begin
                    shreg <= {1'b1, ev_q.num_lefts};
                end else begin
                    shreg <= {shreg[`HDR_CHAR_W-1:0], 1'b0};
                end
            end
            S_LEFTS: shreg <= {shreg[`HDR_CHAR_W-1:0], 1'b0};
            default: ;
        endcase
    end

    assign bit_valid  = (state == S_ZEROS) || (state == S_CHAR) || (state == S_LEFTS);
    // zero run bits are 0, field bits come off the shifter MSB
    assign bit_value  = ((state == S_CHAR) || (state == S_LEFTS)) && shreg[`HDR_CHAR_W];
    assign end_strobe = (state == S_END);

endmodule

`default_nettype wire

// File: design/hdr_byte_packer.sv
`timescale 1ns/1ps
`default_nettype none

module hdr_byte_packer (
    input  logic       clk,
    input  logic       reset,
    input  logic       bit_valid,
    input  logic       bit_value,
    input  logic       end_strobe,
    output logic       byte_valid,
    output logic [7:0] byte_data,
    output logic       byte_last
);

    // newest bit at lsb, older bits above
    logic [7:0] pack_q;
    // bits held in pack_q, 0 means empty
    logic [2:0] fill;
    logic [7:0] shifted;
    // zero bits needed to left-align a partial byte
    logic [3:0] pad;
    logic [7:0] aligned;

    assign shifted = {pack_q[6:0], bit_value};
    assign pad     = 4'd8 - {1'b0, fill};
    // stale bits above fill drop off the top
    assign aligned = (fill == '0) ? 8'h00 : (pack_q << pad);

    // control, single-cycle strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            fill       <= '0;
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            byte_last  <= 1'b0;
            if (end_strobe) begin
                // flush, partial or empty
                byte_valid <= 1'b1;
                byte_last  <= 1'b1;
                fill       <= '0;
            end else if (bit_valid) begin
                // wraps to 0 on the eighth bit
                fill <= fill + 1'b1;
                if (fill == 3'd7) begin
                    byte_valid <= 1'b1;
                end
            end
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        if (end_strobe) begin
            byte_data <= aligned;
        end else if (bit_valid) begin
            pack_q <= shifted;
            if (fill == 3'd7) begin
                byte_data <= shifted;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/huffman_header_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdr_consts.svh"

module huffman_header_writer (
    input  logic                   clk,
    input  logic                   reset,
    // tree walker strobes
    input  logic                   char_found,
    input  logic [`HDR_CHAR_W-1:0] char_index,
    input  logic                   char_left,
    input  logic [`HDR_CHAR_W-1:0] num_lefts,
    input  logic                   backtrack,
    input  logic                   tree_done,
    // header byte stream
    output logic                   byte_valid,
    output logic [7:0]             byte_data,
    output logic                   byte_last,
    // sticky FIFO overflow
    output logic                   overflow
);

    // serializer to packer bit stream
    logic bit_valid;
    logic bit_value;
    logic end_strobe;

    hdr_event_if u_evq_if ();

    // backtrack run folding and event FIFO
    hdr_event_queue u_hdr_event_queue (
        .clk        (clk),
        .reset      (reset),
        .char_found (char_found),
        .char_index (char_index),
        .char_left  (char_left),
        .num_lefts  (num_lefts),
        .backtrack  (backtrack),
        .tree_done  (tree_done),
        .evq        (u_evq_if.queue),
        .overflow   (overflow)
    );

    // events to one bit per cycle
    hdr_bit_serializer u_hdr_bit_serializer (
        .clk        (clk),
        .reset      (reset),
        .evq        (u_evq_if.serializer),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .end_strobe (end_strobe)
    );

    // bits to bytes, MSB first
    hdr_byte_packer u_hdr_byte_packer (
        .clk        (clk),
        .reset      (reset),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .end_strobe (end_strobe),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_last  (byte_last)
    );

endmodule

`default_nettype wire

// File: tb/hdr_ref_model.svh
`ifndef HDR_REF_MODEL_SVH
`define HDR_REF_MODEL_SVH

// expected bytes with bit 8 marking the last byte of a header
logic [8:0] exp_bytes [$];
// bits gathered toward the next byte MSB first
logic [7:0] acc;
int         acc_n;
// backtracks not yet turned into zero bits
int         pend_zeros;

task automatic clear_model();
    exp_bytes.delete();
    acc        = '0;
    acc_n      = 0;
    pend_zeros = 0;
endtask

// append width bits of value MSB first and cut them into bytes
task automatic push_bits(input logic [7:0] value, input int width);
    for (int i = width - 1; i >= 0; i--) begin
        acc = {acc[6:0], value[i]};
        acc_n++;
        if (acc_n == 8) begin
            exp_bytes.push_back({1'b0, acc});
            acc_n = 0;
        end
    end
endtask

// one zero per backtrack since the last event
task automatic emit_zeros();
    for (int i = 0; i < pend_zeros; i++) begin
        push_bits(8'h00, 1);
    end
    pend_zeros = 0;
endtask

// a run reaching the limit goes out as its own zeros-only event
task automatic note_backtracks(input int n);
    for (int i = 0; i < n; i++) begin
        pend_zeros++;
        if (pend_zeros == `HDR_RUN_MAX) begin
            emit_zeros();
        end
    end
endtask

task automatic expect_leaf(input logic [7:0] idx, input logic left, input logic [7:0] nl);
    emit_zeros();
    push_bits(8'h01, 1);
    push_bits(idx, 8);
    // left count field only for a left leaf with lefts pending
    if (left && nl != 8'h00) begin
        push_bits(8'h01, 1);
        push_bits(nl, 8);
    end
endtask

// pad the partial byte or send a bare 0x00 when aligned
task automatic close_header();
    emit_zeros();
    if (acc_n != 0) begin
        exp_bytes.push_back({1'b1, acc << (8 - acc_n)});
    end else begin
        exp_bytes.push_back(9'h100);
    end
    acc   = '0;
    acc_n = 0;
endtask

`endif

// File: tb/tb_huffman_header_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hdr_consts.svh"

module tb_huffman_header_writer;

    logic       clk;
    logic       reset;
    logic       char_found;
    logic [7:0] char_index;
    logic       char_left;
    logic [7:0] num_lefts;
    logic       backtrack;
    logic       tree_done;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_last;
    logic       overflow;

    int     value_errors;
    int     other_errors;
    // byte checker enable, cleared while the FIFO is overrun
    logic   checking;
    integer seed;

    `include "hdr_ref_model.svh"

    huffman_header_writer u_huffman_header_writer (
        .clk        (clk),
        .reset      (reset),
        .char_found (char_found),
        .char_index (char_index),
        .char_left  (char_left),
        .num_lefts  (num_lefts),
        .backtrack  (backtrack),
        .tree_done  (tree_done),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_last  (byte_last),
        .overflow   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // safety net against a stuck run
    initial begin
        #400us;
        $display("simulation ran past its time limit");
        $display("** FAIL **");
        $finish;
    end

    // outputs read at posedge still hold the previous cycle's values
    always @(posedge clk) begin
        logic [8:0] head;
        if (!reset && checking) begin
            assert (!byte_valid || exp_bytes.size() != 0) else begin
                other_errors++;
                $display("unexpected byte 0x%02h at %0t ns", byte_data, $time);
            end
            if (byte_valid && exp_bytes.size() != 0) begin
                head = exp_bytes.pop_front();
                assert (byte_data == head[7:0]) else begin
                    value_errors++;
                    $display("Fail at %0t ns: byte_data got 0x%02h expected 0x%02h",
                             $time, byte_data, head[7:0]);
                end
                // last flag only on the header's closing byte
                assert (byte_last == head[8]) else begin
                    value_errors++;
                    $display("Fail at %0t ns: byte_last got %0b expected %0b",
                             $time, byte_last, head[8]);
                end
            end
            assert (byte_valid || !byte_last) else begin
                other_errors++;
                $display("byte_last high without byte_valid at %0t ns", $time);
            end
            assert (!overflow) else begin
                value_errors++;
                $display("Fail at %0t ns: overflow got 1 expected 0", $time);
            end
        end
    end

    task automatic skip_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        skip_cycles(4);
        reset = 1'b0;
    endtask

    // one leaf strobe where bt adds a backtrack in the same cycle
    task automatic pulse_leaf(input logic [7:0] idx, input logic left,
                              input logic [7:0] nl, input logic bt);
        int gap;
        gap        = pend_zeros + 26;
        char_found = 1'b1;
        char_index = idx;
        char_left  = left;
        num_lefts  = nl;
        backtrack  = bt;
        @(negedge clk);
        char_found = 1'b0;
        backtrack  = 1'b0;
        expect_leaf(idx, left, nl);
        skip_cycles(gap);
    endtask

    // model follows each backtrack as it is sampled
    task automatic run_backtracks(input int n);
        for (int i = 0; i < n; i++) begin
            backtrack = 1'b1;
            @(negedge clk);
            note_backtracks(1);
        end
        backtrack = 1'b0;
    endtask

    task automatic finish_tree();
        int gap;
        gap       = pend_zeros + 8;
        tree_done = 1'b1;
        @(negedge clk);
        tree_done = 1'b0;
        close_header();
        skip_cycles(gap);
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (exp_bytes.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (exp_bytes.size() == 0) else begin
            other_errors++;
            $display("timeout, %0d expected bytes never arrived", exp_bytes.size());
        end
    endtask

    initial begin
        logic [31:0] r;
        seed         = 32'hb10e_eff2;
        reset        = 1'b1;
        char_found   = 1'b0;
        char_index   = 8'h00;
        char_left    = 1'b0;
        num_lefts    = 8'h00;
        backtrack    = 1'b0;
        tree_done    = 1'b0;
        value_errors = 0;
        other_errors = 0;
        checking     = 1'b1;
        clear_model();
        apply_reset();

        // quiet outputs with no strobes
        skip_cycles(20);

        // right leaf ignores num_lefts and left leaf adds it only when nonzero
        pulse_leaf(8'hA5, 1'b0, 8'h03, 1'b0);
        finish_tree();
        pulse_leaf(8'h3C, 1'b1, 8'h02, 1'b0);
        finish_tree();
        pulse_leaf(8'h81, 1'b1, 8'h00, 1'b0);
        finish_tree();
        wait_drained(100);

        // short run then one that saturates the counter
        run_backtracks(3);
        pulse_leaf(8'h42, 1'b0, 8'h00, 1'b0);
        run_backtracks(300);
        pulse_leaf(8'h17, 1'b1, 8'h09, 1'b0);
        pulse_leaf(8'h55, 1'b0, 8'h00, 1'b1);
        pulse_leaf(8'h66, 1'b0, 8'h00, 1'b0);
        finish_tree();
        // saturated run still draining behind the leaves
        wait_drained(400);

        // 11 bits pending then 16 aligned bits
        pulse_leaf(8'hC3, 1'b0, 8'h00, 1'b0);
        run_backtracks(2);
        finish_tree();
        pulse_leaf(8'h0F, 1'b0, 8'h00, 1'b0);
        run_backtracks(7);
        finish_tree();
        wait_drained(100);

        // keep the serializer busy and overrun the FIFO
        checking   = 1'b0;
        char_found = 1'b1;
        char_index = 8'h11;
        char_left  = 1'b1;
        num_lefts  = 8'h05;
        @(negedge clk);
        char_found = 1'b0;
        skip_cycles(2);
        for (int i = 0; i < 9; i++) begin
            char_found = 1'b1;
            char_index = 8'(i);
            @(negedge clk);
        end
        char_found = 1'b0;
        skip_cycles(2);
        assert (overflow) else begin
            other_errors++;
            $display("overflow not raised by nine back-to-back leaves");
        end
        skip_cycles(40);
        assert (overflow) else begin
            other_errors++;
            $display("overflow dropped before reset");
        end
        apply_reset();
        assert (!overflow) else begin
            other_errors++;
            $display("overflow still set after reset");
        end
        clear_model();
        checking = 1'b1;
        pulse_leaf(8'h99, 1'b1, 8'h01, 1'b0);
        finish_tree();
        wait_drained(100);

        // random mix of runs, leaves, left flags and counts
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            run_backtracks({28'd0, r[3:0]});
            pulse_leaf(r[11:4], r[12], r[13] ? 8'h00 : r[21:14], r[22]);
        end
        finish_tree();
        wait_drained(200);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: huffman_header_writer.f
+incdir+design
+incdir+tb
design/hdr_pkg.sv
design/hdr_event_if.sv
design/hdr_event_queue.sv
design/hdr_bit_serializer.sv
design/hdr_byte_packer.sv
design/huffman_header_writer.sv
tb/tb_huffman_header_writer.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_huffman_header_writer
FILELIST  ?= huffman_header_writer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the testbench prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
